// File: vlog.f
+incdir+src
src/mmu_pkg.sv
src/mmu_row_mem.sv
src/mmu_cmd_decode.sv
src/mmu_weight_fifo.sv
src/mmu_pe_array.sv
src/mmu_result_writer.sv
src/mmu_top.sv
tb/mmu_tb.sv

// File: Makefile
# Verilator flow for the matrix-multiply unit

VERILATOR  ?= verilator
FILELIST   ?= vlog.f
TB_TOP     ?= mmu_tb
RTL_TOP    ?= mmu_top
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Test passed
TIMESCALE  ?= 1ns/1ps
VFLAGS     ?= --binary --timing -Wno-fatal --timescale $(TIMESCALE)
LINT_FLAGS ?= --lint-only --timing --timescale $(TIMESCALE)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

# the log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/mmu_tb.sv
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu_tb;
    import mmu_pkg::*;

    localparam int   N           = `MMU_N;
    localparam int   DEPTH       = `MMU_DEPTH;
    localparam int   HALF_PERIOD = 20;                  // 40 ns clock
    localparam int   TEST_COUNT  = 5;
    localparam int   TEST_CYCLES = DEPTH + 4 * N + 20;  // budget per test
    localparam act_t MIN_V       = 8'sh80;              // -128
    localparam act_t MAX_V       = 8'sh7f;              // 127

    logic             clk;
    logic             arst_n;
    logic             in_wr_en;
    addr_t            in_wr_addr;
    act_row_t         in_wr_data;
    logic             w_push;
    act_row_t         w_row;
    logic             cmd_valid;
    cmd_op_e          cmd_op;
    addr_t            cmd_in_base;
    addr_t            cmd_out_base;
    logic [`MMU_AW:0] cmd_rows;
    logic             out_rd_en;
    addr_t            out_rd_addr;
    logic             busy;
    logic             done;
    logic             cmd_err;
    acc_row_t         out_rd_data;

    int       errors;
    act_row_t a_ref [DEPTH];  // mirror of the input memory
    act_row_t w_ref [N];      // w_ref[k] is W[k], array row k
    acc_row_t c_ref [DEPTH];  // expected output memory

    mmu_top mmu_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // ==================================================================
    // watchdog
    // ==================================================================

    initial begin
        repeat (TEST_COUNT * TEST_CYCLES) @(posedge clk);
        $display("timeout: run still going after %0d cycles", TEST_COUNT * TEST_CYCLES);
        $display("Test failed");
        $finish;
    end

    // ==================================================================
    // checks and reference model
    // ==================================================================

    task automatic check_row(input string name, input acc_row_t got, input acc_row_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    // C[j] = sum over k of A[k] * W[k][j], wraps at 32 bits
    function automatic acc_row_t expect_row(input act_row_t a);
        acc_row_t c;
        act_t     x;
        act_t     w;
        for (int j = 0; j < N; j++) begin
            c[j] = '0;
            for (int k = 0; k < N; k++) begin
                x    = a[k];
                w    = w_ref[k][j];
                c[j] = c[j] + acc_t'(x) * acc_t'(w);  // sign extended first
            end
        end
        return c;
    endfunction

    function automatic act_row_t rand_row();
        act_row_t r;
        for (int i = 0; i < N; i++) begin
            r[i] = act_t'($urandom());
        end
        return r;
    endfunction

    // ==================================================================
    // bus tasks, all driving on the falling edge
    // ==================================================================

    // writes n rows of a_ref from base and pushes w_ref alongside
    task automatic stage_inputs(input addr_t base, input int n);
        addr_t ad;
        for (int i = 0; i < n || i < N; i++) begin
            @(negedge clk);
            ad         = base + addr_t'(i);  // wraps like the memory
            in_wr_en   = (i < n);
            in_wr_addr = ad;
            in_wr_data = a_ref[ad];
            w_push     = (i < N);
            w_row      = w_ref[N-1-i];       // bottom row goes in first
        end
        @(negedge clk);
        in_wr_en = 1'b0;
        w_push   = 1'b0;
    endtask

    task automatic send_cmd(input cmd_op_e op, input addr_t ib, input addr_t ob,
                            input int rows, input logic exp_err);
        @(negedge clk);
        cmd_valid    = 1'b1;
        cmd_op       = op;
        cmd_in_base  = ib;
        cmd_out_base = ob;
        cmd_rows     = rows[`MMU_AW:0];
        @(negedge clk);
        cmd_valid = 1'b0;
        check_bit("cmd_err", cmd_err, exp_err);  // pulse lands one cycle on
    endtask

    // cyc counts cycles after the accepting edge
    task automatic wait_done(output int cyc);
        cyc = 0;
        while (!done && cyc < TEST_CYCLES) begin
            @(negedge clk);
            cyc++;
        end
        if (!done) begin
            errors++;
            $display("done never came within %0d cycles", TEST_CYCLES);
        end else begin
            check_bit("busy", busy, 1'b1);  // held through done
        end
    endtask

    task automatic load_weights();
        int cyc;
        send_cmd(OP_LOAD_W, '0, '0, 1, 1'b0);
        wait_done(cyc);
        if (cyc != N + 1) begin
            errors++;
            $display("LOAD_W done came %0d cycles after accept, wanted %0d", cyc, N + 1);
        end
    endtask

    task automatic expect_run(input addr_t ib, input addr_t ob, input int rows);
        for (int r = 0; r < rows; r++) begin
            c_ref[ob + addr_t'(r)] = expect_row(a_ref[ib + addr_t'(r)]);
        end
    endtask

    task automatic run_matmul(input addr_t ib, input addr_t ob, input int rows);
        int cyc;
        expect_run(ib, ob, rows);
        send_cmd(OP_MATMUL, ib, ob, rows, 1'b0);
        wait_done(cyc);
    endtask

    // pipelined readback, data one cycle behind the address
    task automatic read_back(input addr_t ob, input int n);
        addr_t ra;
        for (int i = 0; i <= n; i++) begin
            @(negedge clk);
            if (i > 0) begin
                ra = ob + addr_t'(i - 1);
                check_row($sformatf("out_rd_data[%0d]", ra), out_rd_data, c_ref[ra]);
            end
            out_rd_en   = (i < n);
            out_rd_addr = ob + addr_t'(i);
        end
    endtask

    // ==================================================================
    // directed tests
    // ==================================================================

    task automatic identity_weights();
        for (int k = 0; k < N; k++) begin
            w_ref[k] = '0;
            w_ref[k][k] = 8'sd1;
            a_ref[k] = rand_row();
        end
        stage_inputs(0, 4);
        load_weights();
        run_matmul(0, 0, 4);  // output is the activations sign extended
        read_back(0, 4);
    endtask

    task automatic random_full_run();
        for (int k = 0; k < N; k++) w_ref[k] = rand_row();
        for (int i = 0; i < DEPTH; i++) a_ref[i] = rand_row();
        stage_inputs(5, DEPTH);
        load_weights();
        run_matmul(5, 9, DEPTH);  // both windows wrap
        read_back(9, DEPTH);
    endtask

    task automatic back_to_back_runs();
        for (int pass = 0; pass < 2; pass++) begin
            for (int k = 0; k < N; k++) w_ref[k] = rand_row();
            stage_inputs(0, 0);  // weights only, rows left from before
            load_weights();
            run_matmul(0, 8, 4);
            read_back(8, 4);
        end
    endtask

    task automatic busy_rejection();
        int cyc;
        expect_run(3, 2, 6);
        send_cmd(OP_MATMUL, 3, 2, 6, 1'b0);
        repeat (2) @(negedge clk);
        send_cmd(OP_LOAD_W, '0, '0, 1, 1'b1);  // dropped mid run
        wait_done(cyc);
        read_back(2, 6);
    endtask

    task automatic extreme_values();
        for (int k = 0; k < N; k++) begin
            for (int j = 0; j < N; j++) begin
                w_ref[k][j] = ((k + j) % 2 == 1) ? MAX_V : MIN_V;
            end
        end
        for (int i = 0; i < N; i++) begin
            a_ref[12][i] = MIN_V;
            a_ref[13][i] = MAX_V;
            a_ref[14][i] = (i % 2 == 1) ? MAX_V : MIN_V;
            a_ref[15][i] = (i < 2) ? MIN_V : MAX_V;
        end
        stage_inputs(12, 4);
        load_weights();  // latency checked here too
        run_matmul(12, 14, 4);
        read_back(14, 4);
    endtask

    // ==================================================================
    // main sequence
    // ==================================================================

    initial begin
        void'($urandom(54047));
        errors       = 0;
        arst_n       = 1'b0;
        in_wr_en     = 1'b0;
        in_wr_addr   = '0;
        in_wr_data   = '0;
        w_push       = 1'b0;
        w_row        = '0;
        cmd_valid    = 1'b0;
        cmd_op       = OP_LOAD_W;
        cmd_in_base  = '0;
        cmd_out_base = '0;
        cmd_rows     = '0;
        out_rd_en    = 1'b0;
        out_rd_addr  = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        check_bit("cmd_err", cmd_err, 1'b0);

        identity_weights();
        random_full_run();
        back_to_back_runs();
        busy_rejection();
        extreme_values();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: src/mmu_top.sv
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu_top (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_wr_en,
    input  mmu_pkg::addr_t     in_wr_addr,
    input  mmu_pkg::act_row_t  in_wr_data,
    input  logic               w_push,
    input  mmu_pkg::act_row_t  w_row,
    input  logic               cmd_valid,
    input  mmu_pkg::cmd_op_e   cmd_op,
    input  mmu_pkg::addr_t     cmd_in_base,
    input  mmu_pkg::addr_t     cmd_out_base,
    input  logic [`MMU_AW:0]   cmd_rows,
    input  logic               out_rd_en,
    input  mmu_pkg::addr_t     out_rd_addr,
    output logic               busy,
    output logic               done,
    output logic               cmd_err,
    output mmu_pkg::acc_row_t  out_rd_data
);

    logic               act_rd_en;
    mmu_pkg::addr_t     act_rd_addr;
    mmu_pkg::act_row_t  act_row;     // input memory to array
    logic               row_valid;
    logic               w_shift;
    mmu_pkg::act_row_t  w_head;      // fifo head to array top
    logic               load_done;
    logic               run_start;
    mmu_pkg::addr_t     out_base;
    logic [`MMU_AW:0]   rows;
    mmu_pkg::acc_row_t  col_sums;    // skewed bottom edge
    logic               out_wr_en;
    mmu_pkg::addr_t     out_wr_addr;
    mmu_pkg::acc_row_t  out_wr_data;
    logic               mm_done;

    assign done = load_done | mm_done;

    // ==================================================================
    // decode
    // ==================================================================

    mmu_row_mem #(.row_t(mmu_pkg::act_row_t), .DEPTH(`MMU_DEPTH)) in_mem_inst (
        .clk     (clk),
        .wr_en   (in_wr_en),     // host side
        .wr_addr (in_wr_addr),
        .wr_data (in_wr_data),
        .rd_en   (act_rd_en),    // decode side
        .rd_addr (act_rd_addr),
        .rd_data (act_row)
    );

    mmu_cmd_decode decode_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_in_base  (cmd_in_base),
        .cmd_out_base (cmd_out_base),
        .cmd_rows     (cmd_rows),
        .mm_done      (mm_done),
        .busy         (busy),
        .cmd_err      (cmd_err),
        .act_rd_en    (act_rd_en),
        .act_rd_addr  (act_rd_addr),
        .row_valid    (row_valid),
        .w_shift      (w_shift),
        .load_done    (load_done),
        .run_start    (run_start),
        .out_base     (out_base),
        .rows         (rows)
    );

    // ==================================================================
    // execute
    // ==================================================================

    mmu_weight_fifo weight_fifo_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .push     (w_push),
        .push_row (w_row),
        .shift    (w_shift),
        .head_row (w_head)
    );

    mmu_pe_array pe_array_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .w_shift   (w_shift),
        .w_in      (w_head),
        .row_valid (row_valid),
        .act_in    (act_row),
        .sum_out   (col_sums)
    );

    // ==================================================================
    // result
    // ==================================================================

    mmu_result_writer writer_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .run_start   (run_start),
        .out_base    (out_base),
        .rows        (rows),
        .sum_in      (col_sums),
        .out_wr_en   (out_wr_en),
        .out_wr_addr (out_wr_addr),
        .out_wr_data (out_wr_data),
        .mm_done     (mm_done)
    );

    mmu_row_mem #(.row_t(mmu_pkg::acc_row_t), .DEPTH(`MMU_DEPTH)) out_mem_inst (
        .clk     (clk),
        .wr_en   (out_wr_en),
        .wr_addr (out_wr_addr),
        .wr_data (out_wr_data),
        .rd_en   (out_rd_en),    // host readback
        .rd_addr (out_rd_addr),
        .rd_data (out_rd_data)
    );

endmodule

// File: src/mmu_result_writer.sv
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu_result_writer (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               run_start,
    input  mmu_pkg::addr_t     out_base,
    input  logic [`MMU_AW:0]   rows,
    input  mmu_pkg::acc_row_t  sum_in,
    output logic               out_wr_en,
    output mmu_pkg::addr_t     out_wr_addr,
    output mmu_pkg::acc_row_t  out_wr_data,
    output logic               mm_done
);
    import mmu_pkg::*;

    localparam int N  = `MMU_N;
    localparam int WW = $clog2(2 * N);

    // first row reaches the write port 2N cycles after run_start:
    // one read cycle, N through the array, N-1 of deskew
    localparam logic [WW-1:0] FILL = WW'(2 * N - 1);

    logic             active_q;
    logic [WW-1:0]    wait_q;   // pipeline fill countdown
    logic [`MMU_AW:0] left_q;   // rows still to write
    addr_t            addr_q;

    // ==================================================================
    // deskew, lane j waits N-1-j cycles
    // ==================================================================

    for (genvar j = 0; j < N; j++) begin : g_deskew
        if (j == N - 1) begin : g_pass
            assign out_wr_data[j] = sum_in[j];  // last lane is already latest
        end else begin : g_dly
            acc_t dly_q [N-1-j];
            always_ff @(posedge clk) begin
                dly_q[0] <= sum_in[j];
                for (int i = 1; i < N - 1 - j; i++) begin
                    dly_q[i] <= dly_q[i-1];
                end
            end
            assign out_wr_data[j] = dly_q[N-2-j];
        end
    end

    // ==================================================================
    // write sequencing
    // ==================================================================

    assign out_wr_en   = active_q && (wait_q == '0);
    assign out_wr_addr = addr_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active_q <= 1'b0;
            wait_q   <= '0;
            left_q   <= '0;
            addr_q   <= '0;
            mm_done  <= 1'b0;
        end else begin
            mm_done <= 1'b0;
            if (run_start) begin
                active_q <= 1'b1;
                wait_q   <= FILL;
                left_q   <= rows;
                addr_q   <= out_base;
            end else if (active_q) begin
                if (wait_q != '0) begin
                    wait_q <= wait_q - 1'b1;
                end else begin
                    addr_q <= addr_q + 1'b1;  // one row per cycle
                    left_q <= left_q - 1'b1;
                    if (left_q == 1) begin
                        active_q <= 1'b0;
                        mm_done  <= 1'b1;  // cycle after the last write
                    end
                end
            end
        end
    end

endmodule

// File: src/mmu_pe_array.sv
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu_pe_array (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               w_shift,
    input  mmu_pkg::act_row_t  w_in,
    input  logic               row_valid,
    input  mmu_pkg::act_row_t  act_in,
    output mmu_pkg::acc_row_t  sum_out
);
    import mmu_pkg::*;

    localparam int N = `MMU_N;

    act_t w_q [N][N];  // stationary weight per cell
    acc_t p_q [N][N];  // partial sum leaving each cell downward

    // ==================================================================
    // cell grid, row k holds weights W[k][*]
    // ==================================================================

    for (genvar k = 0; k < N; k++) begin : g_row
        act_t lane_in;
        // one delay chain per row does both the input skew of k cycles
        // and the hop of one cycle per cell to the right
        act_t dly_q [k+N-1];

        assign lane_in = row_valid ? act_in[k] : '0;  // idle cycles add nothing

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                dly_q <= '{default: '0};
            end else begin
                dly_q[0] <= lane_in;
                for (int i = 1; i < k + N - 1; i++) begin
                    dly_q[i] <= dly_q[i-1];
                end
            end
        end

        for (genvar j = 0; j < N; j++) begin : g_col
            act_t a_here;   // lane k delayed k+j
            act_t w_above;
            acc_t p_above;

            if (k + j == 0) begin : g_corner
                assign a_here = lane_in;
            end else begin : g_tap
                assign a_here = dly_q[k+j-1];
            end

            if (k == 0) begin : g_top
                assign w_above = w_in[j];
                assign p_above = '0;
            end else begin : g_below
                assign w_above = w_q[k-1][j];
                assign p_above = p_q[k-1][j];
            end

            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    w_q[k][j] <= '0;
                    p_q[k][j] <= '0;
                end else begin
                    if (w_shift) begin
                        w_q[k][j] <= w_above;  // weights move down one row
                    end
                    p_q[k][j] <= p_above + a_here * w_q[k][j];  // signed mac, wraps
                end
            end
        end
    end

    // bottom edge, column j lands N+j cycles after its row enters
    for (genvar j = 0; j < N; j++) begin : g_out
        assign sum_out[j] = p_q[N-1][j];
    end

endmodule

// File: src/mmu_weight_fifo.sv
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu_weight_fifo (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               push,
    input  mmu_pkg::act_row_t  push_row,
    input  logic               shift,
    output mmu_pkg::act_row_t  head_row
);
    import mmu_pkg::*;

    localparam int N = `MMU_N;

    // row_q[0] is the oldest push, meant for array row N-1
    act_row_t row_q [N];

    // push and shift both advance the chain toward the head
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            row_q <= '{default: '0};
        end else if (push || shift) begin
            for (int i = 0; i < N - 1; i++) begin
                row_q[i] <= row_q[i+1];
            end
            row_q[N-1] <= push ? push_row : '0;  // drain leaves zero weights
        end
    end

    assign head_row = row_q[0];  // feeds the top row of the array

endmodule

// File: src/mmu_cmd_decode.sv
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu_cmd_decode (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cmd_valid,
    input  mmu_pkg::cmd_op_e  cmd_op,
    input  mmu_pkg::addr_t    cmd_in_base,
    input  mmu_pkg::addr_t    cmd_out_base,
    input  logic [`MMU_AW:0]  cmd_rows,
    input  logic              mm_done,
    output logic              busy,
    output logic              cmd_err,
    output logic              act_rd_en,
    output mmu_pkg::addr_t    act_rd_addr,
    output logic              row_valid,
    output logic              w_shift,
    output logic              load_done,
    output logic              run_start,
    output mmu_pkg::addr_t    out_base,
    output logic [`MMU_AW:0]  rows
);
    import mmu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SHIFT,   // weights moving into the array
        STREAM   // activation reads issued, then wait for the writer
    } state_e;

    state_e           state_q;
    logic [`MMU_AW:0] cnt_q;      // shift cycles or rows issued
    addr_t            in_base_q;
    logic             accept;

    assign accept = cmd_valid && !busy;

    // ==================================================================
    // outputs decoded from state
    // ==================================================================

    assign w_shift     = (state_q == SHIFT) && (cnt_q != `MMU_N);  // N cycles
    assign act_rd_en   = (state_q == STREAM) && (cnt_q != rows);
    assign act_rd_addr = in_base_q + cnt_q[`MMU_AW-1:0];           // wraps in memory

    // command payload, only read while busy
    always_ff @(posedge clk) begin
        if (accept) begin
            in_base_q <= cmd_in_base;
            out_base  <= cmd_out_base;
            rows      <= cmd_rows;
        end
    end

    // ==================================================================
    // control FSM
    // ==================================================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= IDLE;
            cnt_q     <= '0;
            busy      <= 1'b0;
            cmd_err   <= 1'b0;
            row_valid <= 1'b0;
            load_done <= 1'b0;
            run_start <= 1'b0;
        end else begin
            cmd_err   <= cmd_valid && busy;  // dropped command
            row_valid <= act_rd_en;          // matches read latency
            load_done <= 1'b0;
            run_start <= 1'b0;
            if (load_done || mm_done) begin
                busy <= 1'b0;                // stays high through done
            end
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        busy  <= 1'b1;
                        cnt_q <= '0;
                        if (cmd_op == OP_LOAD_W) begin
                            state_q <= SHIFT;
                        end else begin
                            state_q   <= STREAM;
                            run_start <= 1'b1;  // writer starts its countdown
                        end
                    end
                end
                SHIFT: begin
                    // one settle cycle after the last shift, then done
                    if (cnt_q == `MMU_N) begin
                        state_q   <= IDLE;
                        load_done <= 1'b1;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                STREAM: begin
                    if (act_rd_en) begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                    if (mm_done) begin
                        state_q <= IDLE;  // last row is in the output memory
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

// File: src/mmu_row_mem.sv
`timescale 1ns/1ps
`include "mmu_params.svh"

module mmu_row_mem #(
    parameter type row_t = mmu_pkg::act_row_t,
    parameter int  DEPTH = `MMU_DEPTH
) (
    input  logic           clk,
    input  logic           wr_en,
    input  mmu_pkg::addr_t wr_addr,
    input  row_t           wr_data,
    input  logic           rd_en,
    input  mmu_pkg::addr_t rd_addr,
    output row_t           rd_data
);
    import mmu_pkg::*;

    row_t mem_q [DEPTH];  // one full row per entry

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_q[wr_addr] <= wr_data;
        end
    end

    // read port, one cycle latency
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem_q[rd_addr];  // holds last value when idle
        end
    end

endmodule

// File: src/mmu_pkg.sv
`include "mmu_params.svh"

package mmu_pkg;

    // ==================================================================
    // element and row types
    // ==================================================================

    typedef logic signed [7:0]  act_t;  // activation or weight
    typedef logic signed [31:0] acc_t;  // column sum, wraps

    // lane 0 is column 0
    typedef act_t [`MMU_N-1:0] act_row_t;
    typedef acc_t [`MMU_N-1:0] acc_row_t;

    typedef logic [`MMU_AW-1:0] addr_t;  // row address into either memory

    // command opcodes
    typedef enum logic {
        OP_LOAD_W = 1'b0,  // staged weights into the array
        OP_MATMUL = 1'b1   // stream activation rows
    } cmd_op_e;

endpackage

// File: src/mmu_params.svh
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// ======================================================================
// array geometry and memory sizing
// ======================================================================

// array edge, also lanes per row
`define MMU_N 4

// rows held by each row memory
`define MMU_DEPTH 16

// row address width, must cover MMU_DEPTH
`define MMU_AW 4

`endif
